//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_data_bus_transmit
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- data_bus_transmit.sv
// two-lane link training transmit top
`default_nettype none

module data_bus_transmit (
	input  wire                          fsm_clk,
	input  wire                          rst,
	input  wire  [os_tx_pkg::LANE_W-1:0] transport_layer_data_in,
	input  wire  [os_tx_pkg::SEL_W-1:0]  d_sel,
	output logic [os_tx_pkg::LANE_W-1:0] lane_0_tx,
	output logic [os_tx_pkg::LANE_W-1:0] lane_1_tx,
	output logic                         os_sent,
	output logic                         tx_lanes_on
);

	// per-peer bus signals
	logic                         slos_grant;
	logic [os_tx_pkg::LANE_W-1:0] slos_byte0;
	logic [os_tx_pkg::LANE_W-1:0] slos_byte1;
	logic                         slos_byte_stb;
	logic                         slos_os_done;
	logic                         g3_grant;
	logic [os_tx_pkg::LANE_W-1:0] g3_byte0;
	logic [os_tx_pkg::LANE_W-1:0] g3_byte1;
	logic                         g3_byte_stb;
	logic                         g3_os_done;
	logic                         g4_grant;
	logic [os_tx_pkg::LANE_W-1:0] g4_byte0;
	logic [os_tx_pkg::LANE_W-1:0] g4_byte1;
	logic                         g4_byte_stb;
	logic                         g4_os_done;

	prbs_slos_gen i_prbs_slos_gen (
		.fsm_clk(fsm_clk), .rst(rst), .grant(slos_grant),
		.byte0(slos_byte0), .byte1(slos_byte1),
		.byte_stb(slos_byte_stb), .os_done(slos_os_done)
	);

	gen3_ts_gen i_gen3_ts_gen (
		.fsm_clk(fsm_clk), .rst(rst), .grant(g3_grant), .d_sel(d_sel),
		.byte0(g3_byte0), .byte1(g3_byte1),
		.byte_stb(g3_byte_stb), .os_done(g3_os_done)
	);

	gen4_ts_gen i_gen4_ts_gen (
		.fsm_clk(fsm_clk), .rst(rst), .grant(g4_grant), .d_sel(d_sel),
		.byte0(g4_byte0), .byte1(g4_byte1),
		.byte_stb(g4_byte_stb), .os_done(g4_os_done)
	);

	lane_arbiter i_lane_arbiter (
		.fsm_clk(fsm_clk), .rst(rst), .d_sel(d_sel),
		.transport_layer_data_in(transport_layer_data_in),
		.slos_grant(slos_grant), .slos_byte0(slos_byte0), .slos_byte1(slos_byte1),
		.slos_byte_stb(slos_byte_stb), .slos_os_done(slos_os_done),
		.g3_grant(g3_grant), .g3_byte0(g3_byte0), .g3_byte1(g3_byte1),
		.g3_byte_stb(g3_byte_stb), .g3_os_done(g3_os_done),
		.g4_grant(g4_grant), .g4_byte0(g4_byte0), .g4_byte1(g4_byte1),
		.g4_byte_stb(g4_byte_stb), .g4_os_done(g4_os_done),
		.lane_0_tx(lane_0_tx), .lane_1_tx(lane_1_tx),
		.os_sent(os_sent), .tx_lanes_on(tx_lanes_on)
	);

endmodule

`default_nettype wire

//--- filelist.f
os_tx_pkg.sv
prbs_slos_gen.sv
gen3_ts_gen.sv
gen4_ts_gen.sv
lane_arbiter.sv
data_bus_transmit.sv
tb_clock_gen.sv
tb_data_bus_transmit.sv

//--- gen3_ts_gen.sv
// gen3 ts1/ts2 serializer
`default_nettype none

module gen3_ts_gen (
	input  wire                          fsm_clk,
	input  wire                          rst,
	input  wire                          grant,
	input  wire  [os_tx_pkg::SEL_W-1:0]  d_sel,
	output logic [os_tx_pkg::LANE_W-1:0] byte0,
	output logic [os_tx_pkg::LANE_W-1:0] byte1,
	output logic                         byte_stb,
	output logic                         os_done
);

	logic [5:0]  bit_idx;   // counts down, msb first
	logic [63:0] ts_lane0;
	logic [63:0] ts_lane1;

	assign ts_lane0 = (d_sel == os_tx_pkg::SEL_G3_TS2) ? os_tx_pkg::G3_TS2_LANE0
		: os_tx_pkg::G3_TS1_LANE0;
	assign ts_lane1 = (d_sel == os_tx_pkg::SEL_G3_TS2) ? os_tx_pkg::G3_TS2_LANE1
		: os_tx_pkg::G3_TS1_LANE1;

	// byte0/byte1 are the shift registers themselves
	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			bit_idx  <= 6'd63;
			byte0    <= '0;
			byte1    <= '0;
			byte_stb <= 1'b0;
			os_done  <= 1'b0;
		end else if (!grant) begin
			bit_idx  <= 6'd63;
			byte0    <= '0;
			byte1    <= '0;
			byte_stb <= 1'b0;
			os_done  <= 1'b0;
		end else begin
			byte0    <= {byte0[os_tx_pkg::LANE_W-2:0], ts_lane0[bit_idx]};
			byte1    <= {byte1[os_tx_pkg::LANE_W-2:0], ts_lane1[bit_idx]};
			bit_idx  <= bit_idx - 6'd1;            // 0 wraps to 63
			byte_stb <= (bit_idx[2:0] == 3'd0);   // eighth bit of a byte
			os_done  <= (bit_idx == 6'd0);
		end
	end

endmodule

`default_nettype wire

//--- gen4_ts_gen.sv
// gen4 ts2/ts3/ts4 header serializer
`default_nettype none

module gen4_ts_gen (
	input  wire                          fsm_clk,
	input  wire                          rst,
	input  wire                          grant,
	input  wire  [os_tx_pkg::SEL_W-1:0]  d_sel,
	output logic [os_tx_pkg::LANE_W-1:0] byte0,
	output logic [os_tx_pkg::LANE_W-1:0] byte1,
	output logic                         byte_stb,
	output logic                         os_done
);

	os_tx_pkg::gen4_header_u      hdr;
	logic [4:0]                   bit_idx;  // 31 down to 0
	logic [3:0]                   ts4_idx;  // 1..15
	logic [os_tx_pkg::LANE_W-1:0] sr;
	logic                         ts4_sel;

	assign ts4_sel = (d_sel == os_tx_pkg::SEL_G4_TS4);

	//////////////////////////////
	// header select
	//////////////////////////////
	always_comb begin
		hdr.raw = os_tx_pkg::G4_TS2_HEAD;
		if (d_sel == os_tx_pkg::SEL_G4_TS3) begin
			hdr.raw = os_tx_pkg::G4_TS3_HEAD;
		end else if (ts4_sel) begin
			hdr.f.os_id   = os_tx_pkg::G4_TS4_ID;
			hdr.f.rsvd_hi = 4'h0;
			hdr.f.index   = ts4_idx;
			hdr.f.index_n = ~ts4_idx;
			hdr.f.rsvd_lo = 4'h0;
		end
	end

	//////////////////////////////
	// serializer
	//////////////////////////////
	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			bit_idx  <= 5'd31;
			sr       <= '0;
			byte_stb <= 1'b0;
			os_done  <= 1'b0;
		end else if (!grant) begin
			bit_idx  <= 5'd31;
			sr       <= '0;
			byte_stb <= 1'b0;
			os_done  <= 1'b0;
		end else begin
			sr       <= {sr[os_tx_pkg::LANE_W-2:0], hdr.raw[bit_idx]};
			bit_idx  <= bit_idx - 5'd1;
			byte_stb <= (bit_idx[2:0] == 3'd0);
			os_done  <= (bit_idx == 5'd0);
		end
	end

	// ts4 index steps once per header, held steady inside a header
	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst)
			ts4_idx <= 4'd1;
		else if (!grant || !ts4_sel)
			ts4_idx <= 4'd1;  // restart on next ts4 run
		else if (bit_idx == 5'd0)
			ts4_idx <= (ts4_idx == 4'd15) ? 4'd1 : ts4_idx + 4'd1;
	end

	assign byte0 = sr;
	assign byte1 = sr;

	a_ts4_idx_nonzero: assert property (@(posedge fsm_clk) disable iff (!rst) ts4_idx != 4'd0)
		else $error("gen4_ts_gen: ts4 index reached zero");

endmodule

`default_nettype wire

//--- lane_arbiter.sv
// lane bus arbiter and output registers
`default_nettype none

module lane_arbiter (
	input  wire                          fsm_clk,
	input  wire                          rst,
	input  wire  [os_tx_pkg::SEL_W-1:0]  d_sel,
	input  wire  [os_tx_pkg::LANE_W-1:0] transport_layer_data_in,
	output logic                         slos_grant,
	input  wire  [os_tx_pkg::LANE_W-1:0] slos_byte0,
	input  wire  [os_tx_pkg::LANE_W-1:0] slos_byte1,
	input  wire                          slos_byte_stb,
	input  wire                          slos_os_done,
	output logic                         g3_grant,
	input  wire  [os_tx_pkg::LANE_W-1:0] g3_byte0,
	input  wire  [os_tx_pkg::LANE_W-1:0] g3_byte1,
	input  wire                          g3_byte_stb,
	input  wire                          g3_os_done,
	output logic                         g4_grant,
	input  wire  [os_tx_pkg::LANE_W-1:0] g4_byte0,
	input  wire  [os_tx_pkg::LANE_W-1:0] g4_byte1,
	input  wire                          g4_byte_stb,
	input  wire                          g4_os_done,
	output logic [os_tx_pkg::LANE_W-1:0] lane_0_tx,
	output logic [os_tx_pkg::LANE_W-1:0] lane_1_tx,
	output logic                         os_sent,
	output logic                         tx_lanes_on
);

	logic [os_tx_pkg::LANE_W-1:0] pick_byte0;
	logic [os_tx_pkg::LANE_W-1:0] pick_byte1;
	logic                         pick_stb;
	logic                         pick_done;
	logic                         os_granted;

	// grant decode
	assign slos_grant = (d_sel == os_tx_pkg::SEL_SLOS1);
	assign g3_grant   = (d_sel == os_tx_pkg::SEL_G3_TS1) || (d_sel == os_tx_pkg::SEL_G3_TS2);
	assign g4_grant   = (d_sel == os_tx_pkg::SEL_G4_TS2) || (d_sel == os_tx_pkg::SEL_G4_TS3) ||
		(d_sel == os_tx_pkg::SEL_G4_TS4);
	assign os_granted = slos_grant | g3_grant | g4_grant;

	// mux from the granted peer
	always_comb begin
		pick_byte0 = slos_byte0;
		pick_byte1 = slos_byte1;
		pick_stb   = slos_byte_stb;
		pick_done  = slos_os_done;
		if (g3_grant) begin
			pick_byte0 = g3_byte0;
			pick_byte1 = g3_byte1;
			pick_stb   = g3_byte_stb;
			pick_done  = g3_os_done;
		end else if (g4_grant) begin
			pick_byte0 = g4_byte0;
			pick_byte1 = g4_byte1;
			pick_stb   = g4_byte_stb;
			pick_done  = g4_os_done;
		end
	end

	//////////////////////////////
	// lane registers
	//////////////////////////////
	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			lane_0_tx   <= '0;
			lane_1_tx   <= '0;
			os_sent     <= 1'b0;
			tx_lanes_on <= 1'b0;
		end else if (os_granted) begin
			if (pick_stb) begin  // lanes hold between strobes
				lane_0_tx   <= pick_byte0;
				lane_1_tx   <= pick_byte1;
				tx_lanes_on <= 1'b1;
			end
			os_sent <= pick_stb & pick_done;
		end else if (d_sel == os_tx_pkg::SEL_DATA) begin
			lane_0_tx   <= transport_layer_data_in;
			lane_1_tx   <= '0;
			os_sent     <= 1'b0;
			tx_lanes_on <= 1'b1;
		end else begin  // idle
			lane_0_tx   <= '0;
			lane_1_tx   <= '0;
			os_sent     <= 1'b0;
			tx_lanes_on <= 1'b0;
		end
	end

	a_one_grant: assert property (@(posedge fsm_clk) disable iff (!rst)
		$onehot0({slos_grant, g3_grant, g4_grant}))
		else $error("lane_arbiter: more than one peer granted");

	a_sent_granted: assert property (@(posedge fsm_clk) disable iff (!rst)
		$rose(os_sent) |-> $past(os_granted))
		else $error("lane_arbiter: os_sent rose without an ordered-set peer");

endmodule

`default_nettype wire

//--- os_tx_pkg.sv
// link training tx definitions
`default_nettype none

package os_tx_pkg;

	//////////////////////////////
	// widths and counts
	//////////////////////////////
	localparam int LANE_W     = 8;
	localparam int SEL_W      = 4;
	localparam int PRBS_W     = 11;
	localparam int SLOS_BYTES = 256;              // bytes per slos1
	localparam int SLOS_CNT_W = $clog2(SLOS_BYTES);

	// d_sel codes (all others idle)
	localparam logic [SEL_W-1:0] SEL_SLOS1  = 4'h0;
	localparam logic [SEL_W-1:0] SEL_G3_TS1 = 4'h2;
	localparam logic [SEL_W-1:0] SEL_G3_TS2 = 4'h3;
	localparam logic [SEL_W-1:0] SEL_G4_TS2 = 4'h5;
	localparam logic [SEL_W-1:0] SEL_G4_TS3 = 4'h6;
	localparam logic [SEL_W-1:0] SEL_G4_TS4 = 4'h7;
	localparam logic [SEL_W-1:0] SEL_DATA   = 4'h8;

	localparam logic [PRBS_W-1:0] PRBS_SEED = 11'd1;

	//////////////////////////////
	// gen3 training sets
	//////////////////////////////
	// lane 1 differs only in the lane number byte
	localparam logic [63:0] G3_TS1_LANE0 = 64'h01000000040098F2;
	localparam logic [63:0] G3_TS2_LANE0 = 64'h01000000040064F2;
	localparam logic [63:0] G3_TS1_LANE1 = 64'h01010000040098F2;
	localparam logic [63:0] G3_TS2_LANE1 = 64'h01010000040064F2;

	//////////////////////////////
	// gen4 headers
	//////////////////////////////
	localparam logic [31:0] G4_TS2_HEAD = 32'h7E04B0F0;
	localparam logic [31:0] G4_TS3_HEAD = 32'h7E0690F0;
	localparam logic [15:0] G4_TS4_ID   = 16'h7E0F;  // fixed upper half of ts4

	typedef struct packed {
		logic [15:0] os_id;
		logic [3:0]  rsvd_hi;  // zero
		logic [3:0]  index;
		logic [3:0]  index_n;  // ~index
		logic [3:0]  rsvd_lo;  // zero
	} gen4_header_s;

	// raw word goes out msb first, fields used to build ts4
	typedef union packed {
		logic [31:0]  raw;
		gen4_header_s f;
	} gen4_header_u;

endpackage

`default_nettype wire

//--- prbs_slos_gen.sv
// slos1 prbs11 byte generator
`default_nettype none

module prbs_slos_gen (
	input  wire                          fsm_clk,
	input  wire                          rst,
	input  wire                          grant,
	output logic [os_tx_pkg::LANE_W-1:0] byte0,
	output logic [os_tx_pkg::LANE_W-1:0] byte1,
	output logic                         byte_stb,
	output logic                         os_done
);

	logic [os_tx_pkg::PRBS_W-1:0]     prbs;
	logic [os_tx_pkg::LANE_W-1:0]     sr;        // bit to byte packer
	logic [2:0]                       bit_cnt;
	logic [os_tx_pkg::SLOS_CNT_W-1:0] byte_cnt;
	logic                             last_bit;

	// final bit of the final byte of one slos1
	assign last_bit = (bit_cnt == 3'd7) &&
		(byte_cnt == os_tx_pkg::SLOS_CNT_W'(os_tx_pkg::SLOS_BYTES - 1));

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			prbs     <= os_tx_pkg::PRBS_SEED;
			sr       <= '0;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			byte_stb <= 1'b0;
			os_done  <= 1'b0;
		end else if (!grant) begin  // back to start state
			prbs     <= os_tx_pkg::PRBS_SEED;
			sr       <= '0;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			byte_stb <= 1'b0;
			os_done  <= 1'b0;
		end else begin
			sr      <= {sr[os_tx_pkg::LANE_W-2:0], prbs[0]};  // bit 0 out first, lands in msb
			bit_cnt <= bit_cnt + 3'd1;
			if (last_bit)
				prbs <= os_tx_pkg::PRBS_SEED;  // next slos1 starts from seed
			else
				prbs <= {prbs[os_tx_pkg::PRBS_W-2:0], prbs[10] ^ prbs[8]};
			if (bit_cnt == 3'd7)
				byte_cnt <= byte_cnt + os_tx_pkg::SLOS_CNT_W'(1);
			byte_stb <= (bit_cnt == 3'd7);
			os_done  <= last_bit;
		end
	end

	// same byte on both lanes
	assign byte0 = sr;
	assign byte1 = sr;

	// a zero state would lock the lfsr up
	a_prbs_nonzero: assert property (@(posedge fsm_clk) disable iff (!rst) prbs != '0)
		else $error("prbs_slos_gen: prbs register all zeros");

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset
`default_nettype none

module tb_clock_gen (
	output logic fsm_clk,
	output logic rst
);

	localparam int HALF_PERIOD  = 20;  // 40 unit period
	localparam int RESET_CYCLES = 4;

	initial begin
		fsm_clk = 1'b0;
		forever #(HALF_PERIOD) fsm_clk = ~fsm_clk;
	end

	// release on a falling edge, clear of the sampling edge
	initial begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge fsm_clk);
		@(negedge fsm_clk);
		rst = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb_data_bus_transmit.sv
// data bus transmit testbench
`default_nettype none

module tb_data_bus_transmit;

	localparam int CLK_PERIOD = 40;
	localparam logic [os_tx_pkg::SEL_W-1:0] SEL_IDLE = 4'hF;
	localparam int HOLD_IDLE  = 4;
	localparam int HOLD_G3    = 300;   // several 8 byte sets
	localparam int HOLD_G4    = 150;
	localparam int HOLD_TS4   = 600;   // past the 15 to 1 index wrap
	localparam int HOLD_TS4_B = 120;
	localparam int HOLD_SLOS  = 4200;  // two full slos1 and more
	localparam int HOLD_DATA  = 64;
	localparam int RUN_CYCLES = 9 * HOLD_IDLE + 2 * HOLD_G3 + 2 * HOLD_G4 + HOLD_TS4 +
		HOLD_TS4_B + HOLD_SLOS + HOLD_DATA;
	localparam int WATCHDOG_TIME = (RUN_CYCLES + 4 + 200) * CLK_PERIOD;

	logic                         fsm_clk;
	logic                         rst;
	logic [os_tx_pkg::LANE_W-1:0] transport_layer_data_in;
	logic [os_tx_pkg::SEL_W-1:0]  d_sel;
	logic [os_tx_pkg::LANE_W-1:0] lane_0_tx;
	logic [os_tx_pkg::LANE_W-1:0] lane_1_tx;
	logic                         os_sent;
	logic                         tx_lanes_on;

	logic [7:0]                   slos_ref [256];  // one slos1 from the prbs11 model
	logic [os_tx_pkg::SEL_W-1:0]  last_sel = SEL_IDLE;
	int                           run_cyc = 0;      // edges since the code changed
	logic                         os_run = 1'b0;
	logic [7:0]                   exp_l0 = '0;
	logic [7:0]                   exp_l1 = '0;
	logic                         exp_sent = 1'b0;
	logic                         exp_on = 1'b0;
	int                           err_count = 0;
	int                           cyc_count = 0;
	integer                       seed = 32'h12e55816;

	tb_clock_gen i_tb_clock_gen (.fsm_clk(fsm_clk), .rst(rst));

	data_bus_transmit i_data_bus_transmit (
		.fsm_clk(fsm_clk), .rst(rst),
		.transport_layer_data_in(transport_layer_data_in), .d_sel(d_sel),
		.lane_0_tx(lane_0_tx), .lane_1_tx(lane_1_tx),
		.os_sent(os_sent), .tx_lanes_on(tx_lanes_on)
	);

	//////////////////////////////
	// reference models
	//////////////////////////////
	function automatic logic code_is_os(input logic [os_tx_pkg::SEL_W-1:0] sel);
		return sel inside {os_tx_pkg::SEL_SLOS1, os_tx_pkg::SEL_G3_TS1, os_tx_pkg::SEL_G3_TS2,
			os_tx_pkg::SEL_G4_TS2, os_tx_pkg::SEL_G4_TS3, os_tx_pkg::SEL_G4_TS4};
	endfunction

	function automatic logic code_is_idle(input logic [os_tx_pkg::SEL_W-1:0] sel);
		return !code_is_os(sel) && (sel != os_tx_pkg::SEL_DATA);
	endfunction

	// bytes per ordered set
	function automatic int set_len(input logic [os_tx_pkg::SEL_W-1:0] sel);
		if (sel == os_tx_pkg::SEL_SLOS1)
			return os_tx_pkg::SLOS_BYTES;
		if (sel == os_tx_pkg::SEL_G3_TS1 || sel == os_tx_pkg::SEL_G3_TS2)
			return 8;
		if (code_is_os(sel))
			return 4;
		return 1;
	endfunction

	// byte n of the stream on one lane
	function automatic logic [7:0] ref_byte(input logic [os_tx_pkg::SEL_W-1:0] sel,
		input logic lane, input int n);
		logic [63:0] g3;
		logic [31:0] g4;
		logic [3:0]  idx;
		g3 = '0;
		g4 = '0;
		idx = 4'((n / 4) % 15 + 1);  // ts4 index of header n/4
		ref_byte = '0;
		case (sel)
			os_tx_pkg::SEL_SLOS1:  ref_byte = slos_ref[8'(n % os_tx_pkg::SLOS_BYTES)];
			os_tx_pkg::SEL_G3_TS1: g3 = lane ? os_tx_pkg::G3_TS1_LANE1 : os_tx_pkg::G3_TS1_LANE0;
			os_tx_pkg::SEL_G3_TS2: g3 = lane ? os_tx_pkg::G3_TS2_LANE1 : os_tx_pkg::G3_TS2_LANE0;
			os_tx_pkg::SEL_G4_TS2: g4 = os_tx_pkg::G4_TS2_HEAD;
			os_tx_pkg::SEL_G4_TS3: g4 = os_tx_pkg::G4_TS3_HEAD;
			os_tx_pkg::SEL_G4_TS4: g4 = {os_tx_pkg::G4_TS4_ID, 4'h0, idx, ~idx, 4'h0};
			default: ;
		endcase
		if (set_len(sel) == 8)
			ref_byte = g3[6'(63 - 8 * (n % 8)) -: 8];  // msb byte first
		else if (set_len(sel) == 4)
			ref_byte = g4[5'(31 - 8 * (n % 4)) -: 8];
	endfunction

	// prbs11, taps 10 and 8, bit 0 out first, packed msb first
	task automatic build_slos_ref();
		logic [10:0] lfsr;
		logic [7:0]  b;
		lfsr = 11'd1;
		for (int i = 0; i < 256; i++) begin
			b = '0;
			for (int j = 0; j < 8; j++) begin
				b = {b[6:0], lfsr[0]};
				lfsr = {lfsr[9:0], lfsr[10] ^ lfsr[8]};
			end
			slos_ref[8'(i)] = b;
		end
	endtask

	// expected outputs after each edge; byte n lands at edge 8(n+1)+1
	always @(posedge fsm_clk) begin : track_run
		int e;
		int n;
		e = (d_sel != last_sel) ? 1 : run_cyc + 1;
		n = (e >= 9) ? (e - 1) / 8 - 1 : 0;
		run_cyc  <= e;
		last_sel <= d_sel;
		os_run   <= code_is_os(d_sel);
		exp_on   <= (e >= 9);
		exp_l0   <= (e >= 9) ? ref_byte(d_sel, 1'b0, n) : 8'h00;
		exp_l1   <= (e >= 9) ? ref_byte(d_sel, 1'b1, n) : 8'h00;
		exp_sent <= (e >= 9) && ((e - 1) % 8 == 0) && ((n + 1) % set_len(d_sel) == 0);
		if (rst)
			cyc_count <= cyc_count + 1;
	end

	task automatic report_mismatch(input string msg);
		err_count++;
		$display("FAILED at time %0t: %s", $time, msg);
	endtask

	//////////////////////////////
	// checks
	//////////////////////////////
	a_reset_zero: assert property (@(posedge fsm_clk) (!rst || !$past(rst)) |->
		(lane_0_tx == '0 && lane_1_tx == '0 && !os_sent && !tx_lanes_on))
		else report_mismatch("outputs not zero during or right after reset");

	a_idle_zero: assert property (@(posedge fsm_clk) disable iff (!rst)
		code_is_idle(d_sel) |=> (lane_0_tx == '0 && lane_1_tx == '0 && !os_sent && !tx_lanes_on))
		else report_mismatch("idle code did not clear lanes and status");

	a_data_pass: assert property (@(posedge fsm_clk) disable iff (!rst)
		(d_sel == os_tx_pkg::SEL_DATA) |=> (lane_0_tx == $past(transport_layer_data_in) &&
		lane_1_tx == '0 && !os_sent && tx_lanes_on))
		else report_mismatch("transport data not passed to lane 0");

	a_os_lanes: assert property (@(posedge fsm_clk) disable iff (!rst)
		os_run |-> (lane_0_tx == exp_l0 && lane_1_tx == exp_l1))
		else report_mismatch($sformatf("lanes %h/%h, expected %h/%h",
			lane_0_tx, lane_1_tx, exp_l0, exp_l1));

	a_os_sent: assert property (@(posedge fsm_clk) disable iff (!rst)
		os_run |-> (os_sent == exp_sent))
		else report_mismatch($sformatf("os_sent %b, expected %b", os_sent, exp_sent));

	a_lanes_on: assert property (@(posedge fsm_clk) disable iff (!rst)
		os_run |-> (tx_lanes_on == exp_on))
		else report_mismatch($sformatf("tx_lanes_on %b, expected %b", tx_lanes_on, exp_on));

	//////////////////////////////
	// stimulus
	//////////////////////////////
	task automatic hold_code(input logic [os_tx_pkg::SEL_W-1:0] sel, input int cycles);
		logic [31:0] rnd;
		repeat (cycles) begin
			@(negedge fsm_clk);
			rnd = $random(seed);
			d_sel = sel;
			transport_layer_data_in = rnd[7:0];
		end
	endtask

	initial begin
		d_sel = SEL_IDLE;
		transport_layer_data_in = '0;
		build_slos_ref();
		@(posedge rst);
		hold_code(SEL_IDLE, HOLD_IDLE);
		hold_code(os_tx_pkg::SEL_G3_TS1, HOLD_G3);
		hold_code(SEL_IDLE, HOLD_IDLE);
		hold_code(os_tx_pkg::SEL_G3_TS2, HOLD_G3);
		hold_code(SEL_IDLE, HOLD_IDLE);
		hold_code(os_tx_pkg::SEL_G4_TS2, HOLD_G4);
		hold_code(SEL_IDLE, HOLD_IDLE);
		hold_code(os_tx_pkg::SEL_G4_TS3, HOLD_G4);
		hold_code(SEL_IDLE, HOLD_IDLE);
		hold_code(os_tx_pkg::SEL_G4_TS4, HOLD_TS4);
		hold_code(SEL_IDLE, HOLD_IDLE);
		hold_code(os_tx_pkg::SEL_G4_TS4, HOLD_TS4_B);  // index starts over at 1
		hold_code(SEL_IDLE, HOLD_IDLE);
		hold_code(os_tx_pkg::SEL_SLOS1, HOLD_SLOS);
		hold_code(SEL_IDLE, HOLD_IDLE);
		hold_code(os_tx_pkg::SEL_DATA, HOLD_DATA);
		hold_code(SEL_IDLE, HOLD_IDLE);
		repeat (2) @(posedge fsm_clk);  // last checks fire
		@(negedge fsm_clk);
		$display("summary: %0d cycles checked, %0d errors", cyc_count, err_count);
		if (err_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired: run did not finish within %0d time units", WATCHDOG_TIME);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
